/* rtl/mig_arb_config.svh */
`ifndef MIG_ARB_CONFIG_SVH
`define MIG_ARB_CONFIG_SVH

// --------------------------------------------------
// data path widths
`define USER_W        16   // user word
`define APP_W         64   // memory word on the native port
`define PACK_RATIO    4    // user words per memory word
`define ADDR_W        28   // native port address

// --------------------------------------------------
// burst shape and address stepping
`define WR_BURST_LEN  1    // memory words per write burst
`define RD_BURST_LEN  4    // memory words per read burst
`define ADDR_STEP     8    // address increment per memory word

// fifo sizes, powers of two
`define WR_FIFO_DEPTH 8
`define RD_FIFO_DEPTH 8

`endif

/* rtl/mig_arb_pkg.sv */
`default_nettype none

`include "mig_arb_config.svh"

package mig_arb_pkg;

  // --------------------------------------------------
  // data and address types
  typedef logic [`ADDR_W-1:0] addr_t;       // native port address
  typedef logic [`USER_W-1:0] user_word_t;  // one user lane
  typedef logic [`APP_W-1:0]  app_word_t;   // one memory word
  typedef logic [3:0]         fifo_count_t; // fill level 0..8

  // native port command encoding
  typedef enum logic [2:0] {
    CMD_WRITE = 3'd0,
    CMD_READ  = 3'd1
  } app_cmd_e;

endpackage

`default_nettype wire

/* rtl/burst_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module burst_fifo
  import mig_arb_pkg::*;
#(
  parameter type payload_t = app_word_t, // slot type
  parameter int  DEPTH     = 8           // power of two, 2..8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush,     // drop everything in one cycle
  input  logic        push,
  input  payload_t    push_data,
  input  logic        pop,
  output payload_t    head,      // word at the read pointer
  output fifo_count_t count,
  output logic        full,
  output logic        empty
);

  localparam int AW = $clog2(DEPTH);

  payload_t    mem [DEPTH]; // storage array
  logic [AW:0] wr_ptr;      // msb is the lap bit
  logic [AW:0] rd_ptr;
  logic        do_push;     // push that actually lands
  logic        do_pop;

  assign empty   = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign count   = fifo_count_t'(wr_ptr - rd_ptr); // lap bit makes this exact
  assign head    = mem[rd_ptr[AW-1:0]];
  assign do_push = push && !full;   // overflow ignored
  assign do_pop  = pop && !empty;   // underflow ignored

  // --------------------------------------------------
  // pointers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush) begin
      wr_ptr <= '0; // both back to slot 0
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= push_data; // head shows it next cycle
    end
  end

endmodule

`default_nettype wire

/* rtl/addr_ring.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mig_arb_config.svh"

module addr_ring
  import mig_arb_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  addr_t addr_begin,
  input  addr_t addr_end,
  input  logic  restart,    // back to addr_begin
  input  logic  advance,    // one memory word consumed
  output addr_t addr
);

  localparam addr_t STEP = addr_t'(`ADDR_STEP);

  addr_t last_step; // beyond this we wrap

  assign last_step = addr_end - STEP;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr <= addr_begin;      // ring starts at begin
    end else if (restart) begin
      addr <= addr_begin;      // restart beats advance
    end else if (advance) begin
      if (addr < last_step) begin
        addr <= addr + STEP;
      end else begin
        addr <= addr_begin;    // wrap
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/word_packer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mig_arb_config.svh"

module word_packer
  import mig_arb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  user_word_t wr_din,
  input  logic       wr_din_vld,
  output logic       push,       // completed memory word
  output app_word_t  push_data
);

  localparam int CW = $clog2(`PACK_RATIO);

  logic [CW-1:0] lane;    // words gathered so far
  app_word_t     shift_q; // partial memory word
  app_word_t     shift_d;

  assign shift_d   = {wr_din, shift_q[`APP_W-1:`USER_W]}; // enter at top, first ends low
  assign push      = wr_din_vld && (lane == CW'(`PACK_RATIO - 1));
  assign push_data = shift_d; // same cycle as fourth word

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane <= '0;
    end else if (wr_din_vld) begin
      lane <= lane + 1'b1; // wraps after the last lane
    end
  end

  always_ff @(posedge clk) begin
    if (wr_din_vld) begin
      shift_q <= shift_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/word_unpacker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mig_arb_config.svh"

module word_unpacker
  import mig_arb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush,      // read stream restart
  input  logic       rd_req,
  input  app_word_t  head,       // read fifo head
  input  logic       empty,
  output logic       pop,
  output user_word_t rd_dout,
  output logic       rd_dout_vld
);

  localparam int LW = $clog2(`PACK_RATIO);

  app_word_t     hold_q;    // memory word being emitted
  logic          hold_vld;
  logic [LW-1:0] lane;      // next lane out, low first
  logic          last_lane;

  assign rd_dout     = hold_q[lane*`USER_W +: `USER_W];
  assign rd_dout_vld = rd_req && hold_vld && !flush; // old word never leaks at restart
  assign last_lane   = (lane == LW'(`PACK_RATIO - 1));
  assign pop         = !hold_vld && !empty && !flush; // refill only when drained

  // --------------------------------------------------
  // hold state and lane counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold_vld <= 1'b0;
      lane     <= '0;
    end else if (flush) begin
      hold_vld <= 1'b0;
      lane     <= '0;
    end else if (pop) begin
      hold_vld <= 1'b1;   // word usable next cycle
      lane     <= '0;
    end else if (rd_dout_vld) begin
      lane <= lane + 1'b1;
      if (last_lane) begin
        hold_vld <= 1'b0; // idle cycle, then next pop
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      hold_q <= head;
    end
  end

endmodule

`default_nettype wire

/* rtl/arb_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mig_arb_config.svh"

module arb_ctrl
  import mig_arb_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        init_calib_complete,
  input  logic        wr_req,
  input  logic        rd_req,
  input  fifo_count_t wr_count,
  input  app_word_t   wr_head,
  input  fifo_count_t rd_count,
  input  addr_t       wr_addr,
  input  addr_t       rd_addr,
  input  logic        app_rdy,
  input  logic        app_wdf_rdy,
  input  app_word_t   app_rd_data,
  input  logic        app_rd_data_valid,
  output logic        wr_pop,
  output logic        rd_push,
  output app_word_t   rd_push_data,
  output logic        wr_advance,
  output logic        rd_advance,
  output logic        wr_restart,
  output logic        rd_restart,
  output logic        app_en,
  output app_cmd_e    app_cmd,
  output addr_t       app_addr,
  output logic        app_wdf_wren,
  output logic        app_wdf_end,
  output app_word_t   app_wdf_data
);

  localparam int            CW     = $clog2(`RD_BURST_LEN) + 1;
  localparam logic [CW-1:0] RD_LEN = CW'(`RD_BURST_LEN);

  typedef enum logic [1:0] {S_IDLE, S_WRITE, S_RD_ISSUE, S_RD_WAIT} state_e;

  state_e        state;
  logic          wr_req_d;    // edge detect
  logic          rd_req_d;
  logic          cmd_done;    // write command taken
  logic          beat_done;   // write beat taken
  logic          wr_skip;     // write ring restarted mid burst
  logic          reload;      // read address refresh cycle
  logic          discard;     // burst belongs to a dead read stream
  logic [CW-1:0] cmd_cnt;     // read commands taken
  logic [CW-1:0] beat_cnt;    // read beats returned
  addr_t         cmd_addr;    // held command address
  logic          cmd_acc;
  logic          beat_acc;
  logic          wr_fin;
  logic          rd_last_cmd;
  logic          rd_fin;
  logic          start_wr;
  logic          start_rd;

  assign wr_restart = wr_req && !wr_req_d;
  assign rd_restart = rd_req && !rd_req_d;

  // --------------------------------------------------
  // native port drive
  assign app_en       = ((state == S_WRITE) && !cmd_done) || ((state == S_RD_ISSUE) && !reload);
  assign app_cmd      = (state == S_RD_ISSUE || state == S_RD_WAIT) ? CMD_READ : CMD_WRITE;
  assign app_addr     = cmd_addr;             // stable until taken
  assign app_wdf_wren = (state == S_WRITE) && !beat_done;
  assign app_wdf_end  = app_wdf_wren;         // one beat per burst
  assign app_wdf_data = wr_head;              // popped only after the beat

  assign cmd_acc  = app_en && app_rdy;
  assign beat_acc = app_wdf_wren && app_wdf_rdy;

  // write side, command and beat in either order
  assign wr_fin     = (state == S_WRITE) && (cmd_done || cmd_acc) && (beat_done || beat_acc);
  assign wr_pop     = wr_fin;
  assign wr_advance = wr_fin && !wr_skip && !wr_restart; // ring already at begin

  // read side
  assign rd_advance   = (state == S_RD_ISSUE) && cmd_acc && !discard && !rd_restart;
  assign rd_last_cmd  = (cmd_cnt == RD_LEN - 1'b1);
  assign rd_push      = app_rd_data_valid && !discard && !rd_restart; // dead beats dropped
  assign rd_push_data = app_rd_data;
  assign rd_fin       = (state == S_RD_WAIT) && ((beat_cnt + CW'(app_rd_data_valid)) == cmd_cnt);

  // writes first, no start on a restart cycle
  assign start_wr = init_calib_complete && !wr_restart && !rd_restart && (wr_count != '0);
  assign start_rd = init_calib_complete && !wr_restart && !rd_restart && rd_req &&
                    (rd_count < fifo_count_t'(`RD_BURST_LEN));

  // --------------------------------------------------
  // fsm
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      wr_req_d  <= 1'b0;
      rd_req_d  <= 1'b0;
      cmd_done  <= 1'b0;
      beat_done <= 1'b0;
      wr_skip   <= 1'b0;
      reload    <= 1'b0;
      discard   <= 1'b0;
      cmd_cnt   <= '0;
      beat_cnt  <= '0;
    end else begin
      wr_req_d <= wr_req;
      rd_req_d <= rd_req;
      case (state)
        S_IDLE: begin
          cmd_done  <= 1'b0;  // fresh burst bookkeeping
          beat_done <= 1'b0;
          wr_skip   <= 1'b0;
          reload    <= 1'b0;
          discard   <= 1'b0;
          cmd_cnt   <= '0;
          beat_cnt  <= '0;
          if (start_wr) begin
            state <= S_WRITE;
          end else if (start_rd) begin
            state <= S_RD_ISSUE;
          end
        end
        S_WRITE: begin
          if (wr_fin) begin
            state <= S_IDLE;
          end else begin
            if (cmd_acc) begin
              cmd_done <= 1'b1;
            end
            if (beat_acc) begin
              beat_done <= 1'b1;
            end
            if (wr_restart) begin
              wr_skip <= 1'b1;
            end
          end
        end
        S_RD_ISSUE: begin
          if (rd_restart) begin
            discard <= 1'b1;
          end
          if (app_rd_data_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
          if (reload) begin
            reload <= 1'b0;   // ring has stepped by now
            if (discard || rd_restart) begin
              state <= S_RD_WAIT; // no more commands for a dead stream
            end
          end else if (cmd_acc) begin
            cmd_cnt <= cmd_cnt + 1'b1;
            if (rd_last_cmd || discard || rd_restart) begin
              state <= S_RD_WAIT;
            end else begin
              reload <= 1'b1;
            end
          end
        end
        S_RD_WAIT: begin
          if (rd_restart) begin
            discard <= 1'b1;
          end
          if (app_rd_data_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
          if (rd_fin) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // command address, captured at start and after each read step
  always_ff @(posedge clk) begin
    if (state == S_IDLE) begin
      cmd_addr <= start_wr ? wr_addr : rd_addr;
    end else if (reload) begin
      cmd_addr <= rd_addr;
    end
  end

endmodule

`default_nettype wire

/* rtl/mig_arbiter_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mig_arb_config.svh"

module mig_arbiter_top
  import mig_arb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       init_calib_complete,
  // user write side
  input  logic       wr_req,
  input  addr_t      wr_addr_begin,
  input  addr_t      wr_addr_end,
  input  user_word_t wr_din,
  input  logic       wr_din_vld,
  output logic       wr_full,
  // user read side
  input  logic       rd_req,
  input  addr_t      rd_addr_begin,
  input  addr_t      rd_addr_end,
  output user_word_t rd_dout,
  output logic       rd_dout_vld,
  // controller native port
  output logic       app_en,
  input  logic       app_rdy,
  output app_cmd_e   app_cmd,
  output addr_t      app_addr,
  input  logic       app_wdf_rdy,
  output logic       app_wdf_wren,
  output logic       app_wdf_end,
  output app_word_t  app_wdf_data,
  input  app_word_t  app_rd_data,
  input  logic       app_rd_data_valid
);

  logic        pk_push;      // packer to write fifo
  app_word_t   pk_data;
  logic        wr_pop;
  app_word_t   wr_head;
  fifo_count_t wr_count;
  logic        wr_advance;
  logic        wr_restart;
  addr_t       wr_addr;      // write ring output
  logic        rd_push;
  app_word_t   rd_push_data;
  fifo_count_t rd_count;
  logic        rd_advance;
  logic        rd_restart;   // also flushes the read side
  addr_t       rd_addr;
  app_word_t   rd_head;
  logic        rd_empty;
  logic        up_pop;       // unpacker pulls a word

  // --------------------------------------------------
  // write path
  word_packer u_packer (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_din     (wr_din),
    .wr_din_vld (wr_din_vld),
    .push       (pk_push),
    .push_data  (pk_data)
  );

  burst_fifo #(
    .payload_t (app_word_t),
    .DEPTH     (`WR_FIFO_DEPTH)
  ) u_wr_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (1'b0),       // write data is never thrown away
    .push      (pk_push),
    .push_data (pk_data),
    .pop       (wr_pop),
    .head      (wr_head),
    .count     (wr_count),
    .full      (wr_full),
    .empty     ()
  );

  addr_ring u_wr_ring (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_begin (wr_addr_begin),
    .addr_end   (wr_addr_end),
    .restart    (wr_restart),
    .advance    (wr_advance),
    .addr       (wr_addr)
  );

  // --------------------------------------------------
  // arbitration
  arb_ctrl u_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .init_calib_complete (init_calib_complete),
    .wr_req              (wr_req),
    .rd_req              (rd_req),
    .wr_count            (wr_count),
    .wr_head             (wr_head),
    .rd_count            (rd_count),
    .wr_addr             (wr_addr),
    .rd_addr             (rd_addr),
    .app_rdy             (app_rdy),
    .app_wdf_rdy         (app_wdf_rdy),
    .app_rd_data         (app_rd_data),
    .app_rd_data_valid   (app_rd_data_valid),
    .wr_pop              (wr_pop),
    .rd_push             (rd_push),
    .rd_push_data        (rd_push_data),
    .wr_advance          (wr_advance),
    .rd_advance          (rd_advance),
    .wr_restart          (wr_restart),
    .rd_restart          (rd_restart),
    .app_en              (app_en),
    .app_cmd             (app_cmd),
    .app_addr            (app_addr),
    .app_wdf_wren        (app_wdf_wren),
    .app_wdf_end         (app_wdf_end),
    .app_wdf_data        (app_wdf_data)
  );

  // --------------------------------------------------
  // read path
  addr_ring u_rd_ring (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_begin (rd_addr_begin),
    .addr_end   (rd_addr_end),
    .restart    (rd_restart),
    .advance    (rd_advance),
    .addr       (rd_addr)
  );

  burst_fifo #(
    .payload_t (app_word_t),
    .DEPTH     (`RD_FIFO_DEPTH)
  ) u_rd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (rd_restart),
    .push      (rd_push),
    .push_data (rd_push_data),
    .pop       (up_pop),
    .head      (rd_head),
    .count     (rd_count),
    .full      (),           // burst sizing keeps room
    .empty     (rd_empty)
  );

  word_unpacker u_unpacker (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (rd_restart),
    .rd_req      (rd_req),
    .head        (rd_head),
    .empty       (rd_empty),
    .pop         (up_pop),
    .rd_dout     (rd_dout),
    .rd_dout_vld (rd_dout_vld)
  );

endmodule

`default_nettype wire

/* bench/mig_arb_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module mig_arb_checker
  import mig_arb_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     init_calib_complete,
  input logic     app_en,
  input logic     app_rdy,
  input app_cmd_e app_cmd,
  input addr_t    app_addr,
  input logic     app_wdf_wren
);

  // no commands before calibration
  a_calib_gate: assert property (@(posedge clk) disable iff (!rst_n)
    app_en |-> init_calib_complete) else $error("app_en without calibration");

  // held command must not move
  a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (app_en && !app_rdy) |=> ($stable(app_cmd) && $stable(app_addr)))
    else $error("command changed while stalled");

  a_wdf_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    app_wdf_wren |-> (app_cmd == CMD_WRITE)) else $error("write beat on a read");

endmodule

bind arb_ctrl mig_arb_checker u_checker (
  .clk(clk), .rst_n(rst_n), .init_calib_complete(init_calib_complete), .app_en(app_en),
  .app_rdy(app_rdy), .app_cmd(app_cmd), .app_addr(app_addr), .app_wdf_wren(app_wdf_wren)
);

`default_nettype wire

/* bench/tb_mig_model.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mig_model
  import mig_arb_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      app_en,
  input  app_cmd_e  app_cmd,
  input  addr_t     app_addr,
  input  logic      app_wdf_wren,
  input  app_word_t app_wdf_data,
  output logic      app_rdy,
  output logic      app_wdf_rdy,
  output app_word_t app_rd_data,
  output logic      app_rd_data_valid
);

  app_word_t mem [addr_t];   // sparse array
  addr_t     wa_q [$];       // write commands waiting for data
  app_word_t wd_q [$];       // data waiting for a command
  logic      ret_go;         // random return slot
  logic      rq_push, rq_pop, rq_empty;
  addr_t     rq_head;

  // unwritten memory reads back an address-derived pattern
  function automatic app_word_t fill_word(input addr_t a);
    return {4'ha, a, 4'h5, a ^ 28'h5a5_a5a5};
  endfunction

  assign rq_push = app_en && app_rdy && (app_cmd == CMD_READ);
  assign rq_pop  = ret_go && !rq_empty;

  burst_fifo #(.payload_t(addr_t), .DEPTH(8)) u_ret_q (
    .clk(clk), .rst_n(rst_n), .flush(1'b0), .push(rq_push), .push_data(app_addr),
    .pop(rq_pop), .head(rq_head), .count(), .full(), .empty(rq_empty)
  );

  initial begin
    app_rdy = 1'b0;
    app_wdf_rdy = 1'b0;
    app_rd_data = '0;
    app_rd_data_valid = 1'b0;
    ret_go = 1'b0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      app_rdy           <= 1'b0;
      app_wdf_rdy       <= 1'b0;
      ret_go            <= 1'b0;
      app_rd_data_valid <= 1'b0;
    end else begin
      app_rdy           <= ($urandom % 4) != 0;  // about one stall in four
      app_wdf_rdy       <= ($urandom % 3) != 0;
      ret_go            <= ($urandom % 2) == 1;  // varying read latency
      app_rd_data_valid <= rq_pop;
      if (rq_pop) begin
        app_rd_data <= mem.exists(rq_head) ? mem[rq_head] : fill_word(rq_head);
      end
      if (app_en && app_rdy && app_cmd == CMD_WRITE) wa_q.push_back(app_addr);
      if (app_wdf_wren && app_wdf_rdy) wd_q.push_back(app_wdf_data);
      while (wa_q.size() > 0 && wd_q.size() > 0) begin
        mem[wa_q.pop_front()] = wd_q.pop_front();  // command and beat paired
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mig_arb_config.svh"

module tb_monitor
  import mig_arb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       init_calib_complete,
  input  logic       wr_req,
  input  addr_t      wr_addr_begin,
  input  addr_t      wr_addr_end,
  input  user_word_t wr_din,
  input  logic       wr_din_vld,
  input  logic       wr_full,
  input  logic       rd_req,
  input  addr_t      rd_addr_begin,
  input  addr_t      rd_addr_end,
  input  user_word_t rd_dout,
  input  logic       rd_dout_vld,
  input  logic       app_en,
  input  logic       app_rdy,
  input  app_cmd_e   app_cmd,
  input  addr_t      app_addr,
  input  logic       app_wdf_wren,
  input  logic       app_wdf_end,
  input  logic       app_wdf_rdy,
  input  app_word_t  app_wdf_data,
  output int         mon_err,
  output int         mon_wr,
  output int         mon_rd
);

  user_word_t user_q [$];    // every user word written
  app_word_t  image [addr_t]; // reference memory
  addr_t      wa_q [$];
  app_word_t  wd_q [$];
  addr_t      wb, we, rb, re; // ring bounds at last restart
  int         wr_n, rd_k;     // positions since restart
  logic       wr_req_q, rd_req_q;

  function automatic app_word_t fill_word(input addr_t a);
    return {4'ha, a, 4'h5, a ^ 28'h5a5_a5a5};
  endfunction

  // n-th address of a ring: step while below end minus one step, else wrap
  function automatic addr_t ring_addr(input int n, input addr_t b, input addr_t e);
    addr_t a;
    a = b;
    for (int i = 0; i < n; i++) begin
      a = (a < e - addr_t'(`ADDR_STEP)) ? a + addr_t'(`ADDR_STEP) : b;
    end
    return a;
  endfunction

  // memory word g from user words, low lane first
  function automatic app_word_t packed_word(input int g);
    app_word_t w;
    w = '0;
    for (int l = 0; l < `PACK_RATIO; l++) begin
      w[l*`USER_W +: `USER_W] = user_q[g*`PACK_RATIO + l];
    end
    return w;
  endfunction

  initial begin
    mon_err = 0;
    mon_wr = 0;
    mon_rd = 0;
    wr_n = 0;
    rd_k = 0;
    wr_req_q = 1'b0;
    rd_req_q = 1'b0;
  end

  always @(posedge clk) begin
    addr_t      a;
    app_word_t  w;
    user_word_t u;
    logic       full_exp;
    if (rst_n) begin
      // write fifo holds packed words not yet written out
      full_exp = (user_q.size() / `PACK_RATIO - mon_wr) >= `WR_FIFO_DEPTH;
      if (wr_full !== full_exp) begin
        $display("Mismatch at %0t: wr_full expected %b got %b", $time, full_exp, wr_full);
        mon_err++;
      end
      if (wr_req && !wr_req_q) begin
        wr_n = 0;              // write ring restart
        wb = wr_addr_begin;
        we = wr_addr_end;
      end
      if (rd_req && !rd_req_q) begin
        rd_k = 0;              // read stream restart
        rb = rd_addr_begin;
        re = rd_addr_end;
      end
      wr_req_q = wr_req;
      rd_req_q = rd_req;
      if (wr_din_vld) user_q.push_back(wr_din);
      if (app_en && !init_calib_complete) begin
        $display("command issued at %0t before calibration finished", $time);
        mon_err++;
      end
      if (app_wdf_wren && app_wdf_end !== 1'b1) begin
        $display("Mismatch at %0t: app_wdf_end expected 1 got %b", $time, app_wdf_end);
        mon_err++;
      end
      if (app_en && app_rdy && app_cmd == CMD_WRITE) wa_q.push_back(app_addr);
      if (app_wdf_wren && app_wdf_rdy) wd_q.push_back(app_wdf_data);
      // --------------------------------------------------
      // write bursts, command and beat in either order
      while (wa_q.size() > 0 && wd_q.size() > 0) begin
        a = ring_addr(wr_n, wb, we);
        w = packed_word(mon_wr);
        if (wa_q[0] !== a) begin
          $display("Mismatch at %0t: app_addr expected %h got %h", $time, a, wa_q[0]);
          mon_err++;
        end
        if (wd_q[0] !== w) begin
          $display("Mismatch at %0t: app_wdf_data expected %h got %h", $time, w, wd_q[0]);
          mon_err++;
        end
        void'(wa_q.pop_front());
        void'(wd_q.pop_front());
        image[a] = w;          // later writes overwrite
        wr_n++;
        mon_wr++;
      end
      // --------------------------------------------------
      // read stream
      if (rd_dout_vld) begin
        a = ring_addr(rd_k / `PACK_RATIO, rb, re);
        w = image.exists(a) ? image[a] : fill_word(a);
        u = w[(rd_k % `PACK_RATIO)*`USER_W +: `USER_W];
        if (rd_dout !== u) begin
          $display("Mismatch at %0t: rd_dout expected %h got %h", $time, u, rd_dout);
          mon_err++;
        end
        rd_k++;
        mon_rd++;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_top.sv */
`timescale 1ns/10ps
`default_nettype none

// --------------------------------------------------
// clock and reset source
module tb_clkgen #(
  parameter int PERIOD = 100
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;                   // held low from time zero
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;                  // four cycles of reset
  end

endmodule

module tb_top
  import mig_arb_pkg::*;
;

  localparam int CYCLE       = 100;
  localparam int TOTAL_WORDS = 8 + 32 + 24 + 48 + 32; // user words over all tests

  logic       clk, rst_n, init_calib_complete;
  logic       wr_req, wr_din_vld, wr_full, rd_req, rd_dout_vld;
  addr_t      wr_addr_begin, wr_addr_end, rd_addr_begin, rd_addr_end, app_addr;
  user_word_t wr_din, rd_dout;
  logic       app_en, app_rdy, app_wdf_rdy, app_wdf_wren, app_wdf_end, app_rd_data_valid;
  app_cmd_e   app_cmd;
  app_word_t  app_wdf_data, app_rd_data;
  int         mon_err, mon_wr, mon_rd;     // monitor progress
  int         local_err;                   // failures seen here
  int         err_mark;
  int         tests_ok;
  int         tests_bad;
  int         base;

  tb_clkgen #(.PERIOD(CYCLE)) u_clkgen (.clk(clk), .rst_n(rst_n));

  mig_arbiter_top UUT (.*);

  tb_mig_model u_model (
    .clk(clk), .rst_n(rst_n), .app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
    .app_wdf_wren(app_wdf_wren), .app_wdf_data(app_wdf_data), .app_rdy(app_rdy),
    .app_wdf_rdy(app_wdf_rdy), .app_rd_data(app_rd_data),
    .app_rd_data_valid(app_rd_data_valid)
  );

  tb_monitor u_monitor (.*);

  // one user word, only offered while the write fifo has room
  task automatic send_word(input user_word_t d);
    do begin
      @(negedge clk);
    end while (wr_full);
    @(posedge clk);
    wr_din     <= d;
    wr_din_vld <= 1'b1;
    @(posedge clk);
    wr_din_vld <= 1'b0;
  endtask

  task automatic send_random(input int n);
    for (int i = 0; i < n; i++) begin
      send_word(user_word_t'($urandom));
    end
  endtask

  // waits for write beats or read words, bounded
  task automatic wait_progress(input bit reads, input int target);
    int cyc;
    cyc = 0;
    while (((reads ? mon_rd : mon_wr) < target) && (cyc < 20000)) begin
      @(negedge clk);
      cyc++;
    end
    if (cyc >= 20000) begin
      $display("timed out waiting for %s to reach %0d", reads ? "read words" : "writes", target);
      local_err++;
    end
  endtask

  task automatic end_test(input int num, input string name);
    @(negedge clk);                  // monitor settled for this edge
    if (mon_err + local_err == err_mark) begin
      $display("test %0d %s: ok", num, name);
      tests_ok++;
    end else begin
      $display("test %0d %s: failed", num, name);
      tests_bad++;
    end
    err_mark = mon_err + local_err;
  endtask

  // --------------------------------------------------
  // watchdog
  initial begin
    #(TOTAL_WORDS * 400 * CYCLE);
    $display("watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  // --------------------------------------------------
  // stimulus
  initial begin
    init_calib_complete = 1'b0;
    wr_req = 1'b0;
    wr_din = '0;
    wr_din_vld = 1'b0;
    rd_req = 1'b0;
    wr_addr_begin = '0;
    wr_addr_end = '0;
    rd_addr_begin = '0;
    rd_addr_end = '0;
    local_err = 0;
    err_mark = 0;
    tests_ok = 0;
    tests_bad = 0;
    void'($urandom(32'h4091_c5f5));  // single seed for the run
    wait (rst_n === 1'b1);
    @(posedge clk);
    // calibration gate
    wr_addr_begin <= addr_t'('h1000);
    wr_addr_end   <= addr_t'('h1080);
    wr_req        <= 1'b1;
    send_random(8);
    repeat (20) @(negedge clk);
    if (mon_wr != 0) begin
      $display("memory writes happened before calibration finished");
      local_err++;
    end
    @(posedge clk);
    init_calib_complete <= 1'b1;
    wait_progress(1'b0, 2);
    end_test(1, "writes held until calibration");
    // eight memory words from the ring start
    @(posedge clk);
    wr_req <= 1'b0;
    @(posedge clk);
    wr_req <= 1'b1;                  // ring back to begin
    send_random(32);
    wait_progress(1'b0, 10);
    end_test(2, "packed writes under back-pressure");
    // three-slot ring wraps twice
    @(posedge clk);
    wr_req        <= 1'b0;
    wr_addr_begin <= addr_t'('h2000);
    wr_addr_end   <= addr_t'('h2018);
    @(posedge clk);
    wr_req <= 1'b1;
    send_random(24);
    wait_progress(1'b0, 16);
    end_test(3, "write ring wrap");
    // continuous read over eight words, wraps once
    @(posedge clk);
    rd_addr_begin <= addr_t'('h1000);
    rd_addr_end   <= addr_t'('h1040);
    rd_req        <= 1'b1;
    wait_progress(1'b1, 48);
    @(posedge clk);
    rd_req <= 1'b0;
    end_test(4, "read stream in ring order");
    // two passes over the short ring
    repeat (10) @(posedge clk);
    rd_addr_begin <= addr_t'('h2000);
    rd_addr_end   <= addr_t'('h2018);
    rd_req        <= 1'b1;
    base = mon_rd;
    wait_progress(1'b1, base + 16);
    @(posedge clk);
    rd_req <= 1'b0;
    repeat (10) @(posedge clk);
    rd_req <= 1'b1;                  // restart, same words again
    base = mon_rd;
    wait_progress(1'b1, base + 16);
    @(posedge clk);
    rd_req <= 1'b0;
    end_test(5, "read restart");
    repeat (20) @(negedge clk);
    $display("tests passed %0d failed %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && mon_err + local_err == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/mig_arb_pkg.sv
rtl/burst_fifo.sv
rtl/addr_ring.sv
rtl/word_packer.sv
rtl/word_unpacker.sv
rtl/arb_ctrl.sv
rtl/mig_arbiter_top.sv
bench/mig_arb_checker.sv
bench/tb_mig_model.sv
bench/tb_monitor.sv
bench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_top -f src.f -o Vtb_top

./obj_dir/Vtb_top | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
